// ==== all.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/seq_pkg.sv
rtl/req_buf_if.sv
rtl/req_buf.sv
rtl/fetch_sequencer.sv
rtl/rsp_stage.sv
rtl/miss_loader.sv
rtl/block_fetcher.sv
sim/tb_block_fetcher.sv

// ==== rtl/block_fetcher.sv ====
/* Instruction block fetcher in front of a cache with one cycle read latency.
   Responses return in request order; one line fill is outstanding at a time */
`timescale 1ns/1ns
`default_nettype none

`include "fetcher_cfg.svh"

module block_fetcher (
    input  logic              aclk,
    input  logic              aresetn,
    // Request channel
    input  logic              req_valid,
    output logic              req_ready,
    input  fetch_pkg::addr_t  req_addr,
    input  fetch_pkg::id_t    req_id,
    // Response channel
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output fetch_pkg::id_t    rsp_id,
    output fetch_pkg::word_t  rsp_data,
    // Memory controller read
    output logic              mem_arvalid,
    input  logic              mem_arready,
    output fetch_pkg::addr_t  mem_araddr,
    output fetch_pkg::id_t    mem_arid,
    // Cache read port
    output logic              cache_ren,
    output fetch_pkg::addr_t  cache_raddr,
    input  fetch_pkg::word_t  cache_rdata,
    input  logic              cache_hit,
    input  logic              cache_miss,
    input  logic              cache_writing
);

    req_buf_if req_if ();
    req_buf_if miss_if ();

    logic                  hit_valid;
    fetch_pkg::id_t        hit_id;
    logic                  hold;
    logic                  load_start;
    fetch_pkg::fetch_req_t load_req;
    logic                  loading;
    logic                  load_done;

    ////////////////////////////////////////////////////////////
    // Request intake
    ////////////////////////////////////////////////////////////

    assign req_ready     = !req_if.full;
    assign req_if.push   = req_valid && req_ready;
    assign req_if.wdata  = '{addr: req_addr, id: req_id};

    req_buf #(.DEPTH(`FETCH_REQ_DEPTH)) u_req_buf (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (req_if.buffer)
    );

    // Parked misses and their shadowed reads
    req_buf #(.DEPTH(`FETCH_MISS_DEPTH)) u_miss_buf (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (miss_if.buffer)
    );

    ////////////////////////////////////////////////////////////
    // Control, response and line fill
    ////////////////////////////////////////////////////////////

    fetch_sequencer u_seq (
        .aclk (aclk), .aresetn (aresetn),
        .rsp_ready (rsp_ready), .hold (hold),
        .loading (loading), .load_done (load_done),
        .cache_hit (cache_hit), .cache_miss (cache_miss),
        .req_q (req_if.consumer),
        .miss_push (miss_if.producer), .miss_pull (miss_if.consumer),
        .cache_ren (cache_ren), .cache_raddr (cache_raddr),
        .hit_valid (hit_valid), .hit_id (hit_id),
        .load_start (load_start), .load_req (load_req)
    );

    rsp_stage u_rsp (
        .aclk (aclk), .aresetn (aresetn),
        .hit_valid (hit_valid), .hit_id (hit_id),
        .cache_rdata (cache_rdata), .rsp_ready (rsp_ready),
        .rsp_valid (rsp_valid), .rsp_id (rsp_id),
        .rsp_data (rsp_data), .hold (hold)
    );

    miss_loader u_loader (
        .aclk (aclk), .aresetn (aresetn),
        .load_start (load_start), .load_req (load_req),
        .mem_arready (mem_arready), .cache_writing (cache_writing),
        .mem_arvalid (mem_arvalid), .mem_araddr (mem_araddr),
        .mem_arid (mem_arid), .loading (loading), .load_done (load_done)
    );

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
/* Transaction types shared by the fetch path. Widths come from the config header */
`default_nettype none

`include "fetcher_cfg.svh"

package fetch_pkg;

    // Instruction address, ID and data word
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;
    typedef logic [`FETCH_ID_W-1:0]   id_t;
    typedef logic [`FETCH_DATA_W-1:0] word_t;

    // Request record as stored in both buffers
    // Address sits in the upper bits
    typedef struct packed {
        addr_t addr;
        id_t   id;
    } fetch_req_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_sequencer.sv ====
/* Cache read control. Reads issue only when the response side can take a hit;
   replays run one read at a time and pull the miss buffer only on a hit */
`timescale 1ns/1ns
`default_nettype none

module fetch_sequencer (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  rsp_ready,
    input  logic                  hold,
    input  logic                  loading,
    input  logic                  load_done,
    input  logic                  cache_hit,
    input  logic                  cache_miss,
    req_buf_if.consumer           req_q,
    req_buf_if.producer           miss_push,
    req_buf_if.consumer           miss_pull,
    output logic                  cache_ren,
    output fetch_pkg::addr_t      cache_raddr,
    output logic                  hit_valid,
    output fetch_pkg::id_t        hit_id,
    output logic                  load_start,
    output fetch_pkg::fetch_req_t load_req
);

    seq_pkg::seq_state_t   state;

    // Read in flight, answered by the cache one cycle later
    logic                  inflight;
    // The read in flight came from the miss buffer
    logic                  inflight_replay;
    // Read issued in the cycle of a miss, parked whatever it returns
    logic                  shadow;
    fetch_pkg::fetch_req_t inflight_rec;

    fetch_pkg::fetch_req_t issue_rec;
    logic                  go;
    logic                  issue_fetch;
    logic                  issue_replay;
    logic                  miss_evt;
    logic                  shadow_evt;

    ////////////////////////////////////////////////////////////
    // Cache read issue
    ////////////////////////////////////////////////////////////

    // A hit next cycle must be able to leave or be held
    assign go = rsp_ready && !hold && !loading;

    // Back to back reads while serving new requests
    assign issue_fetch = (state == seq_pkg::SEQ_FETCH) && !req_q.empty && go;

    // Replay keeps the head in place until it hits, so order survives a second miss
    assign issue_replay = (state == seq_pkg::SEQ_MISSED) && !miss_pull.empty
                          && !inflight && go;

    assign issue_rec   = (state == seq_pkg::SEQ_MISSED) ? miss_pull.rdata : req_q.rdata;
    assign cache_ren   = issue_fetch || issue_replay;
    assign cache_raddr = issue_rec.addr;
    assign req_q.pull  = issue_fetch;

    ////////////////////////////////////////////////////////////
    // Cache answer handling
    ////////////////////////////////////////////////////////////

    assign miss_evt   = cache_miss && !shadow;
    assign shadow_evt = shadow && (cache_hit || cache_miss);

    // Hits go straight to the response stage
    assign hit_valid = cache_hit && !shadow;
    assign hit_id    = inflight_rec.id;

    // Replayed head leaves the buffer once it hit
    assign miss_pull.pull = hit_valid && inflight_replay;

    // New misses and shadowed reads are parked; a replayed miss is still at the head
    assign miss_push.push  = shadow_evt || (miss_evt && !inflight_replay);
    assign miss_push.wdata = inflight_rec;

    // One line fill per miss
    assign load_start = miss_evt;
    assign load_req   = inflight_rec;

    // Record of the read in flight
    always_ff @(posedge aclk) begin
        if (cache_ren) begin
            inflight_rec <= issue_rec;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            inflight        <= 1'b0;
            inflight_replay <= 1'b0;
            shadow          <= 1'b0;
        end else begin
            inflight        <= cache_ren;
            inflight_replay <= issue_replay;
            // Only the read issued alongside the miss report can be shadowed
            if (miss_evt) begin
                shadow <= cache_ren;
            end else if (shadow_evt) begin
                shadow <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= seq_pkg::SEQ_IDLE;
        end else if (miss_evt) begin
            // A miss wins in any state
            state <= seq_pkg::SEQ_LOAD;
        end else begin
            case (state)
                seq_pkg::SEQ_IDLE: begin
                    if (!req_q.empty) state <= seq_pkg::SEQ_FETCH;
                end
                seq_pkg::SEQ_FETCH: begin
                    if (req_q.empty) state <= seq_pkg::SEQ_IDLE;
                end
                seq_pkg::SEQ_LOAD: begin
                    if (load_done) state <= seq_pkg::SEQ_MISSED;
                end
                seq_pkg::SEQ_MISSED: begin
                    // Drained and last replay answered
                    if (miss_pull.empty && !inflight) state <= seq_pkg::SEQ_FETCH;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetcher_cfg.svh ====
/* Sizing of the block fetcher. Buffer depths need not be powers of two.
   The miss buffer must hold at least two records, a miss and its shadowed read */
`ifndef FETCHER_CFG_SVH
`define FETCHER_CFG_SVH

////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////

// Byte address of an instruction
`define FETCH_ADDR_W 32
// Transaction ID carried from request to response
`define FETCH_ID_W 8
// One instruction word
`define FETCH_DATA_W 32

////////////////////////////////////////////////////////////
// Buffer depths
////////////////////////////////////////////////////////////

`define FETCH_REQ_DEPTH 4
`define FETCH_MISS_DEPTH 8

`endif

// ==== rtl/miss_loader.sv ====
/* Memory read for a missed line. Only one fill is outstanding at a time,
   a new load_start is ignored until the previous fill has been written */
`timescale 1ns/1ns
`default_nettype none

module miss_loader (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  load_start,
    input  fetch_pkg::fetch_req_t load_req,
    input  logic                  mem_arready,
    input  logic                  cache_writing,
    output logic                  mem_arvalid,
    output fetch_pkg::addr_t      mem_araddr,
    output fetch_pkg::id_t        mem_arid,
    output logic                  loading,
    output logic                  load_done
);

    seq_pkg::loader_state_t state;

    // Missed request, held for the address phase
    fetch_pkg::addr_t       miss_addr;
    fetch_pkg::id_t         miss_id;

    ////////////////////////////////////////////////////////////
    // Loader FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= seq_pkg::LDR_IDLE;
        end else begin
            case (state)
                seq_pkg::LDR_IDLE: begin
                    if (load_start) state <= seq_pkg::LDR_REQ;
                end
                // Address held until the controller takes it
                seq_pkg::LDR_REQ: begin
                    if (mem_arready) state <= seq_pkg::LDR_WAIT;
                end
                // Line on its way into the cache
                seq_pkg::LDR_WAIT: begin
                    if (cache_writing) state <= seq_pkg::LDR_IDLE;
                end
                default: begin
                    state <= seq_pkg::LDR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == seq_pkg::LDR_IDLE) && load_start) begin
            miss_addr <= load_req.addr;
            miss_id   <= load_req.id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    // Rises the cycle after load_start
    assign mem_arvalid = (state == seq_pkg::LDR_REQ);
    assign mem_araddr  = miss_addr;
    assign mem_arid    = miss_id;

    // From acceptance to the cycle after the fill
    assign loading   = (state == seq_pkg::LDR_WAIT);
    assign load_done = loading && cache_writing;

endmodule

`default_nettype wire

// ==== rtl/req_buf.sv ====
/* Synchronous FIFO of request records. rdata shows the head with no read latency,
   a pushed record is visible one cycle later */
`timescale 1ns/1ns
`default_nettype none

module req_buf #(
    parameter int DEPTH = 4
) (
    input  logic      aclk,
    input  logic      aresetn,
    req_buf_if.buffer bus
);

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkg::fetch_req_t mem [DEPTH];

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    // Number of records held
    logic [CNT_W-1:0] count;

    // Record array, written at the write pointer
    always_ff @(posedge aclk) begin
        if (bus.push) begin
            mem[wptr] <= bus.wdata;
        end
    end

    // Pointers wrap at DEPTH, so any depth works
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (bus.push) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (bus.pull) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
        end
    end

    // Occupancy, a push and a pull together leave it unchanged
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count <= '0;
        end else begin
            case ({bus.push, bus.pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Status and head
    ////////////////////////////////////////////////////////////

    assign bus.full  = (count == CNT_W'(DEPTH));
    assign bus.empty = (count == '0);
    assign bus.rdata = mem[rptr];

endmodule

`default_nettype wire

// ==== rtl/req_buf_if.sv ====
/* Push and pull sides of one request buffer. Users never push while full
   and never pull while empty */
`timescale 1ns/1ns
`default_nettype none

interface req_buf_if;

    // Write side
    logic                   push;
    fetch_pkg::fetch_req_t  wdata;
    logic                   full;

    // Read side, rdata is the oldest record
    logic                   pull;
    fetch_pkg::fetch_req_t  rdata;
    logic                   empty;

    // Whoever fills the buffer
    modport producer (output push, output wdata, input full);

    // Whoever drains the buffer
    modport consumer (output pull, input rdata, input empty);

    // The FIFO itself
    modport buffer (
        input  push, input  wdata, input  pull,
        output full, output rdata, output empty
    );

endinterface

`default_nettype wire

// ==== rtl/rsp_stage.sv ====
/* Response channel. A hit is offered in its own cycle; on a stall it is held
   and hold stops further cache reads until it is taken */
`timescale 1ns/1ns
`default_nettype none

module rsp_stage (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              hit_valid,
    input  fetch_pkg::id_t    hit_id,
    input  fetch_pkg::word_t  cache_rdata,
    input  logic              rsp_ready,
    output logic              rsp_valid,
    output fetch_pkg::id_t    rsp_id,
    output fetch_pkg::word_t  rsp_data,
    output logic              hold
);

    // Holding register
    logic              held_valid;
    fetch_pkg::id_t    held_id;
    fetch_pkg::word_t  held_data;

    ////////////////////////////////////////////////////////////
    // Output mux
    ////////////////////////////////////////////////////////////

    // Held response first, hits never arrive while it is full
    assign rsp_valid = held_valid || hit_valid;
    assign rsp_id    = held_valid ? held_id : hit_id;
    assign rsp_data  = held_valid ? held_data : cache_rdata;
    assign hold      = held_valid;

    ////////////////////////////////////////////////////////////
    // Stall capture
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            held_valid <= 1'b0;
        end else if (held_valid) begin
            if (rsp_ready) held_valid <= 1'b0;
        end else if (hit_valid && !rsp_ready) begin
            held_valid <= 1'b1;
        end
    end

    // Payload frozen while held, so ID and data stay stable
    always_ff @(posedge aclk) begin
        if (!held_valid && hit_valid) begin
            held_id   <= hit_id;
            held_data <= cache_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/seq_pkg.sv ====
/* State encodings of the fetch sequencer and of the miss loader */
`default_nettype none

package seq_pkg;

    // Sequencer: wait, serve requests, wait for a line fill, replay misses
    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_FETCH  = 2'd1,
        SEQ_LOAD   = 2'd2,
        SEQ_MISSED = 2'd3
    } seq_state_t;

    // Miss loader: no miss, read presented, line fill outstanding
    typedef enum logic [1:0] {
        LDR_IDLE = 2'd0,
        LDR_REQ  = 2'd1,
        LDR_WAIT = 2'd2
    } loader_state_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the block fetcher testbench with Verilator.
# The exit status is the simulator's, so a failed run returns non-zero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    -f all.f \
    --top-module tb_block_fetcher \
    -Mdir obj_dir \
    -o sim_block_fetcher
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_block_fetcher
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== sim/tb_block_fetcher.sv ====
/* Testbench with a one cycle cache model, a memory model with random delays
   and an in-order scoreboard. Addresses cover 16 lines of 16 bytes */
`timescale 1ns/1ns
`default_nettype none

module tb_block_fetcher;

    localparam int          NUM_REQ     = 300;
    // Last four requests go into the full buffer test
    localparam int          STALL_START = 296;
    localparam int          CLK_PERIOD  = 100;
    localparam int          WATCHDOG_NS = NUM_REQ * 40 * CLK_PERIOD;
    localparam logic [31:0] DATA_KEY    = 32'ha5a5_5a5a;

    logic              aclk;
    logic              aresetn;
    logic              req_valid;
    logic              req_ready;
    fetch_pkg::addr_t  req_addr;
    fetch_pkg::id_t    req_id;
    logic              rsp_valid;
    logic              rsp_ready;
    fetch_pkg::id_t    rsp_id;
    fetch_pkg::word_t  rsp_data;
    logic              mem_arvalid;
    logic              mem_arready;
    fetch_pkg::addr_t  mem_araddr;
    fetch_pkg::id_t    mem_arid;
    logic              cache_ren;
    fetch_pkg::addr_t  cache_raddr;
    fetch_pkg::word_t  cache_rdata;
    logic              cache_hit;
    logic              cache_miss;
    logic              cache_writing;

    // Stimulus and model state
    logic [31:0]       lfsr;
    logic [15:0]       present;
    logic [15:0]       filling;
    fetch_pkg::addr_t  sb_addr [$];
    fetch_pkg::id_t    sb_id [$];
    int                issued;
    int                accepted;
    int                answered;
    int                gap;
    logic              req_taken;
    logic              stall_mode;
    int                stall_checks;
    // Cache read waiting for its answer
    logic              rd_pend;
    fetch_pkg::addr_t  rd_addr;
    // Line fill in progress
    logic              fill_busy;
    logic [3:0]        fill_line;
    int                fill_cnt;
    int                ar_wait;
    int                ar_delay;
    // Previous cycle, for stability checks
    logic              rsp_stalled;
    fetch_pkg::id_t    last_rsp_id;
    fetch_pkg::word_t  last_rsp_data;
    logic              ar_stalled;
    fetch_pkg::addr_t  last_araddr;

    block_fetcher u_dut (
        .aclk (aclk), .aresetn (aresetn),
        .req_valid (req_valid), .req_ready (req_ready),
        .req_addr (req_addr), .req_id (req_id),
        .rsp_valid (rsp_valid), .rsp_ready (rsp_ready),
        .rsp_id (rsp_id), .rsp_data (rsp_data),
        .mem_arvalid (mem_arvalid), .mem_arready (mem_arready),
        .mem_araddr (mem_araddr), .mem_arid (mem_arid),
        .cache_ren (cache_ren), .cache_raddr (cache_raddr),
        .cache_rdata (cache_rdata), .cache_hit (cache_hit),
        .cache_miss (cache_miss), .cache_writing (cache_writing)
    );

    ////////////////////////////////////////////////////////////
    // Clock, watchdog, helpers
    ////////////////////////////////////////////////////////////

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d of %0d requests answered", answered, NUM_REQ);
        stop_run();
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Input drive, a small delay after the rising edge
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        logic [31:0] line_sel;
        logic [31:0] word_sel;
        // Line fill lands in the cache
        cache_writing = 1'b0;
        if (fill_busy) begin
            if (fill_cnt == 0) begin
                cache_writing      = 1'b1;
                present[fill_line] = 1'b1;
                filling[fill_line] = 1'b0;
                fill_busy          = 1'b0;
            end else begin
                fill_cnt--;
            end
        end
        // Cache answers the read of the previous cycle
        cache_hit   = rd_pend && present[rd_addr[7:4]];
        cache_miss  = rd_pend && !present[rd_addr[7:4]];
        cache_rdata = rd_pend ? (rd_addr ^ DATA_KEY) : '0;
        mem_arready = (ar_wait >= ar_delay);
        rsp_ready   = stall_mode ? 1'b0 : (rand_bits(2) != 32'd0);
        // Request channel, valid held until taken
        if (req_taken) begin
            req_valid = 1'b0;
            gap       = stall_mode ? 0 : int'(rand_bits(2));
        end
        if (!req_valid) begin
            if (gap > 0) begin
                gap--;
            end else if (issued < STALL_START || (stall_mode && issued < NUM_REQ)) begin
                line_sel  = rand_bits(4);
                word_sel  = rand_bits(2);
                req_valid = 1'b1;
                req_addr  = {24'h0, line_sel[3:0], word_sel[1:0], 2'b00};
                req_id    = fetch_pkg::id_t'(issued);
                issued++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Sampling at the falling edge, where outputs are settled
    ////////////////////////////////////////////////////////////

    task automatic sample_edge();
        int         idx;
        logic       found;
        logic [3:0] line;
        // Full request buffer with the response side stalled
        if (stall_mode && accepted == NUM_REQ) begin
            check_equal("req_ready with full buffer", 32'd0, 32'(req_ready));
            stall_checks++;
            if (stall_checks == 3) stall_mode = 1'b0;
        end
        req_taken = req_valid && req_ready;
        if (req_taken) begin
            sb_addr.push_back(req_addr);
            sb_id.push_back(req_id);
            accepted++;
        end

        // Response held stable under back-pressure
        if (rsp_stalled) begin
            check_equal("rsp_valid held", 32'd1, 32'(rsp_valid));
            check_equal("rsp_id held", 32'(last_rsp_id), 32'(rsp_id));
            check_equal("rsp_data held", last_rsp_data, rsp_data);
        end
        if (rsp_valid && rsp_ready) begin
            if (sb_id.size() == 0) begin
                $display("Response with ID %h came with no outstanding request", rsp_id);
                stop_run();
            end else begin
                check_equal("response id", 32'(sb_id[0]), 32'(rsp_id));
                check_equal("response data", sb_addr[0] ^ DATA_KEY, rsp_data);
                void'(sb_id.pop_front());
                void'(sb_addr.pop_front());
                answered++;
            end
        end
        rsp_stalled   = rsp_valid && !rsp_ready;
        last_rsp_id   = rsp_id;
        last_rsp_data = rsp_data;

        rd_pend = cache_ren;
        rd_addr = cache_raddr;

        // Memory read held until accepted
        if (ar_stalled) begin
            check_equal("mem_arvalid held", 32'd1, 32'(mem_arvalid));
            check_equal("mem_araddr held", last_araddr, mem_araddr);
        end
        if (mem_arvalid && mem_arready) begin
            line  = mem_araddr[7:4];
            found = 1'b0;
            for (idx = 0; idx < sb_id.size(); idx++) begin
                if (!found && sb_id[idx] == mem_arid) begin
                    found = 1'b1;
                    check_equal("mem read line", 32'(sb_addr[idx][7:4]), 32'(line));
                end
            end
            if (!found) begin
                $display("Memory read with ID %h names no outstanding request", mem_arid);
                stop_run();
            end else begin
                check_equal("mem read of present line", 32'd0, 32'(present[line]));
                check_equal("mem read of filling line", 32'd0, 32'(filling[line]));
                filling[line] = 1'b1;
                fill_busy     = 1'b1;
                fill_line     = line;
                fill_cnt      = 1 + int'(rand_bits(3) % 32'd5);
                ar_wait       = 0;
                ar_delay      = int'(rand_bits(2));
            end
        end else if (mem_arvalid) begin
            ar_wait++;
        end
        ar_stalled  = mem_arvalid && !mem_arready;
        last_araddr = mem_araddr;

        // Last four requests go in only once everything has drained
        if (!stall_mode && stall_checks == 0 && accepted == STALL_START
            && issued == STALL_START && sb_id.size() == 0) begin
            stall_mode = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        lfsr          = 32'h587e6b3b;
        aresetn       = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        req_id        = '0;
        rsp_ready     = 1'b0;
        mem_arready   = 1'b0;
        cache_rdata   = '0;
        cache_hit     = 1'b0;
        cache_miss    = 1'b0;
        cache_writing = 1'b0;
        present       = '0;
        filling       = '0;
        issued        = 0;
        accepted      = 0;
        answered      = 0;
        gap           = 0;
        req_taken     = 1'b0;
        stall_mode    = 1'b0;
        stall_checks  = 0;
        rd_pend       = 1'b0;
        rd_addr       = '0;
        fill_busy     = 1'b0;
        fill_line     = '0;
        fill_cnt      = 0;
        ar_wait       = 0;
        ar_delay      = 0;
        rsp_stalled   = 1'b0;
        last_rsp_id   = '0;
        last_rsp_data = '0;
        ar_stalled    = 1'b0;
        last_araddr   = '0;

        repeat (5) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // Idle outputs after reset
        @(negedge aclk);
        check_equal("reset rsp_valid", 32'd0, 32'(rsp_valid));
        check_equal("reset mem_arvalid", 32'd0, 32'(mem_arvalid));
        check_equal("reset cache_ren", 32'd0, 32'(cache_ren));
        check_equal("reset req_ready", 32'd1, 32'(req_ready));

        while (answered < NUM_REQ) begin
            @(posedge aclk);
            #1;
            drive_inputs();
            @(negedge aclk);
            sample_edge();
        end

        if (sb_id.size() != 0 || !req_ready) begin
            $display("Run ended with %0d requests outstanding or req_ready low", sb_id.size());
            stop_run();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
